//--- compile.f
+incdir+testbench
source/vector_add_pkg.sv
source/wb_region_decode.sv
source/ctrl_regs.sv
source/wb_dual_port_ram.sv
source/vector_add_core.sv
source/vector_add_top.sv
testbench/tb_vector_add.sv

//--- source/ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
    input  var logic                    s_wb_clk_i,
    input  var logic                    s_wb_rst_i,
    input  var vector_add_pkg::wb_req_t req_i,
    input  var logic                    done_i,
    output var vector_add_pkg::wb_rsp_t rsp_o,
    output var logic                    start_o
);

    import vector_add_pkg::*;

    logic                     reg_start;
    logic                     reg_done;
    logic                     wr_en;
    logic [MEM_ADDR_BITS-1:0] offset;

    // merge write data into the old value per byte lane
    function automatic logic [WB_DAT_BITS-1:0] write_mask(
        input logic [WB_DAT_BITS-1:0] org,
        input logic [WB_DAT_BITS-1:0] wdat,
        input logic [WB_SEL_BITS-1:0] sel
    );
        logic [WB_DAT_BITS-1:0] res;
        for (int i = 0; i < WB_DAT_BITS; i++) begin
            res[i] = sel[i / (WB_DAT_BITS / WB_SEL_BITS)] ? wdat[i] : org[i];
        end
        return res;
    endfunction

    assign offset = req_i.adr[MEM_ADDR_BITS-1:0];
    assign wr_en  = req_i.stb && req_i.we;

    // ------------------------------------------------------------------------
    //  register write
    // ------------------------------------------------------------------------

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            reg_start <= 1'b0;
            reg_done  <= 1'b0;
        end else begin
            // start is a one-cycle pulse
            reg_start <= 1'b0;

            if (done_i) begin
                reg_done <= 1'b1;
            end

            if (wr_en) begin
                case (offset)
                    ADR_START: reg_start <= 1'(write_mask(WB_DAT_BITS'(reg_start),
                                                          req_i.dat, req_i.sel));
                    ADR_DONE:  reg_done  <= 1'(write_mask(WB_DAT_BITS'(reg_done),
                                                          req_i.dat, req_i.sel));
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------------------------------------------------
    //  register read, ack in the same cycle
    // ------------------------------------------------------------------------

    always_comb begin
        rsp_o.dat = '0;
        case (offset)
            ADR_START: rsp_o.dat = WB_DAT_BITS'(reg_start);
            ADR_DONE:  rsp_o.dat = WB_DAT_BITS'(reg_done);
            default: ;
        endcase
        rsp_o.ack = req_i.stb;
    end

    assign start_o = reg_start;

endmodule

`default_nettype wire

//--- source/vector_add_core.sv
`timescale 1ns/1ps
`default_nettype none

module vector_add_core (
    input  var logic                                      s_wb_clk_i,
    input  var logic                                      s_wb_rst_i,
    input  var logic                                      start_i,

    output var logic [vector_add_pkg::MEM_ADDR_BITS-1:0]  raddr_o,
    output var logic                                      done_o,

    input  var logic [vector_add_pkg::WB_DAT_BITS-1:0]    mem0_rdata_i,
    input  var logic [vector_add_pkg::WB_DAT_BITS-1:0]    mem1_rdata_i,
    output var vector_add_pkg::core_wr_t                  wr_o
);

    import vector_add_pkg::*;

    logic                                        busy;
    logic                                        idle;
    logic                                        last_issue;
    logic [MEM_ADDR_BITS-1:0]                    raddr;
    logic [MEM_LATENCY-1:0]                      pipe_vld;
    logic [MEM_LATENCY-1:0][MEM_ADDR_BITS-1:0]   pipe_addr;
    logic [WB_DAT_BITS-1:0]                      sum;

    // ------------------------------------------------------------------------
    //  read address sequencer
    // ------------------------------------------------------------------------

    // a run lasts until the pipeline has drained
    assign idle       = !busy && !(|pipe_vld);
    assign last_issue = (raddr == MEM_ADDR_BITS'(MEM_DEPTH - 1));

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            busy  <= 1'b0;
            raddr <= '0;
        end else if (busy) begin
            raddr <= raddr + 1'b1;
            if (last_issue) begin
                busy <= 1'b0;
            end
        end else if (start_i && idle) begin
            busy  <= 1'b1;
            raddr <= '0;
        end
    end

    assign raddr_o = raddr;

    // ------------------------------------------------------------------------
    //  delay line matching the RAM latency
    // ------------------------------------------------------------------------

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            pipe_vld <= '0;
            done_o   <= 1'b0;
        end else begin
            pipe_vld <= {pipe_vld[MEM_LATENCY-2:0], busy};
            done_o   <= pipe_vld[MEM_LATENCY-1]
                        && (pipe_addr[MEM_LATENCY-1] == MEM_ADDR_BITS'(MEM_DEPTH - 1));
        end
    end

    always_ff @(posedge s_wb_clk_i) begin
        pipe_addr <= {pipe_addr[MEM_LATENCY-2:0], raddr};
    end

    // ------------------------------------------------------------------------
    //  lane adders, wrap modulo 256
    // ------------------------------------------------------------------------

    for (genvar l = 0; l < WB_DAT_BITS / LANE_BITS; l++) begin : g_lane
        assign sum[l*LANE_BITS +: LANE_BITS] = mem0_rdata_i[l*LANE_BITS +: LANE_BITS]
                                             + mem1_rdata_i[l*LANE_BITS +: LANE_BITS];
    end

    always_comb begin
        wr_o.we   = pipe_vld[MEM_LATENCY-1];
        wr_o.addr = pipe_addr[MEM_LATENCY-1];
        wr_o.data = sum;
    end

endmodule

`default_nettype wire

//--- source/vector_add_pkg.sv
package vector_add_pkg;

    // ------------------------------------------------------------------------
    //  widths and sizes
    // ------------------------------------------------------------------------

    localparam int WB_DAT_BITS   = 32;
    localparam int WB_SEL_BITS   = 4;
    localparam int LANE_BITS     = 8;
    localparam int MEM_ADDR_BITS = 4;
    localparam int MEM_DEPTH     = 16;
    localparam int REGION_BITS   = 2;
    localparam int WB_ADR_BITS   = 6;

    // region field is the top of the word address
    localparam logic [REGION_BITS-1:0] REGION_REGS = 2'd0;
    localparam logic [REGION_BITS-1:0] REGION_MEM0 = 2'd1;
    localparam logic [REGION_BITS-1:0] REGION_MEM1 = 2'd2;
    localparam logic [REGION_BITS-1:0] REGION_MEM2 = 2'd3;

    // offsets inside the register region
    localparam logic [MEM_ADDR_BITS-1:0] ADR_START = 4'd0;
    localparam logic [MEM_ADDR_BITS-1:0] ADR_DONE  = 4'd1;

    localparam int MEM_LATENCY = 2;

    // ------------------------------------------------------------------------
    //  bus and core types
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic [WB_ADR_BITS-1:0] adr;
        logic [WB_DAT_BITS-1:0] dat;
        logic [WB_SEL_BITS-1:0] sel;
        logic                   we;
        logic                   stb;
    } wb_req_t;

    typedef struct packed {
        logic [WB_DAT_BITS-1:0] dat;
        logic                   ack;
    } wb_rsp_t;

    typedef struct packed {
        logic                     we;
        logic [MEM_ADDR_BITS-1:0] addr;
        logic [WB_DAT_BITS-1:0]   data;
    } core_wr_t;

endpackage

//--- source/vector_add_top.sv
`timescale 1ns/1ps
`default_nettype none

module vector_add_top (
    input  var logic                                     s_wb_clk_i,
    input  var logic                                     s_wb_rst_i,
    input  var logic [vector_add_pkg::WB_ADR_BITS-1:0]   s_wb_adr_i,
    input  var logic [vector_add_pkg::WB_DAT_BITS-1:0]   s_wb_dat_i,
    input  var logic [vector_add_pkg::WB_SEL_BITS-1:0]   s_wb_sel_i,
    input  var logic                                     s_wb_we_i,
    input  var logic                                     s_wb_stb_i,
    output var logic [vector_add_pkg::WB_DAT_BITS-1:0]   s_wb_dat_o,
    output var logic                                     s_wb_ack_o
);

    import vector_add_pkg::*;

    wb_req_t                  bus_req;
    wb_rsp_t                  bus_rsp;

    wb_req_t                  regs_req;
    wb_req_t                  mem0_req;
    wb_req_t                  mem1_req;
    wb_req_t                  mem2_req;
    wb_rsp_t                  regs_rsp;
    wb_rsp_t                  mem0_rsp;
    wb_rsp_t                  mem1_rsp;
    wb_rsp_t                  mem2_rsp;

    logic                     start;
    logic                     done;
    logic [MEM_ADDR_BITS-1:0] core_raddr;
    logic [WB_DAT_BITS-1:0]   mem0_rdata;
    logic [WB_DAT_BITS-1:0]   mem1_rdata;
    core_wr_t                 core_wr;

    assign bus_req = '{adr: s_wb_adr_i, dat: s_wb_dat_i, sel: s_wb_sel_i,
                       we: s_wb_we_i, stb: s_wb_stb_i};

    assign s_wb_dat_o = bus_rsp.dat;
    assign s_wb_ack_o = bus_rsp.ack;

    // ------------------------------------------------------------------------
    //  bus side
    // ------------------------------------------------------------------------

    wb_region_decode u_region_decode (
        .req_i      (bus_req),
        .regs_req_o (regs_req),
        .mem0_req_o (mem0_req),
        .mem1_req_o (mem1_req),
        .mem2_req_o (mem2_req),
        .regs_rsp_i (regs_rsp),
        .mem0_rsp_i (mem0_rsp),
        .mem1_rsp_i (mem1_rsp),
        .mem2_rsp_i (mem2_rsp),
        .rsp_o      (bus_rsp)
    );

    ctrl_regs u_ctrl_regs (
        .s_wb_clk_i (s_wb_clk_i),
        .s_wb_rst_i (s_wb_rst_i),
        .req_i      (regs_req),
        .done_i     (done),
        .rsp_o      (regs_rsp),
        .start_o    (start)
    );

    // ------------------------------------------------------------------------
    //  memories, mem0/mem1 read by the core, mem2 written by it
    // ------------------------------------------------------------------------

    wb_dual_port_ram #(.CORE_WRITES(1'b0)) u_mem0 (
        .s_wb_clk_i   (s_wb_clk_i),
        .s_wb_rst_i   (s_wb_rst_i),
        .req_i        (mem0_req),
        .rsp_o        (mem0_rsp),
        .core_raddr_i (core_raddr),
        .core_wr_i    (),
        .core_rdata_o (mem0_rdata)
    );

    wb_dual_port_ram #(.CORE_WRITES(1'b0)) u_mem1 (
        .s_wb_clk_i   (s_wb_clk_i),
        .s_wb_rst_i   (s_wb_rst_i),
        .req_i        (mem1_req),
        .rsp_o        (mem1_rsp),
        .core_raddr_i (core_raddr),
        .core_wr_i    (),
        .core_rdata_o (mem1_rdata)
    );

    wb_dual_port_ram #(.CORE_WRITES(1'b1)) u_mem2 (
        .s_wb_clk_i   (s_wb_clk_i),
        .s_wb_rst_i   (s_wb_rst_i),
        .req_i        (mem2_req),
        .rsp_o        (mem2_rsp),
        .core_raddr_i (),
        .core_wr_i    (core_wr),
        .core_rdata_o ()
    );

    vector_add_core u_core (
        .s_wb_clk_i   (s_wb_clk_i),
        .s_wb_rst_i   (s_wb_rst_i),
        .start_i      (start),
        .raddr_o      (core_raddr),
        .done_o       (done),
        .mem0_rdata_i (mem0_rdata),
        .mem1_rdata_i (mem1_rdata),
        .wr_o         (core_wr)
    );

endmodule

`default_nettype wire

//--- source/wb_dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

module wb_dual_port_ram #(
    parameter bit CORE_WRITES = 1'b0
) (
    input  var logic                                      s_wb_clk_i,
    input  var logic                                      s_wb_rst_i,
    input  var vector_add_pkg::wb_req_t                   req_i,
    output var vector_add_pkg::wb_rsp_t                   rsp_o,

    input  var logic [vector_add_pkg::MEM_ADDR_BITS-1:0]  core_raddr_i,
    input  var vector_add_pkg::core_wr_t                  core_wr_i,
    output var logic [vector_add_pkg::WB_DAT_BITS-1:0]    core_rdata_o
);

    import vector_add_pkg::*;

    logic [WB_DAT_BITS-1:0]   mem [MEM_DEPTH];

    logic                     accept;
    logic [MEM_LATENCY-1:0]   pend;
    logic [MEM_ADDR_BITS-1:0] wb_addr;
    logic [WB_SEL_BITS-1:0]   wb_be;
    logic [WB_DAT_BITS-1:0]   wb_rd_q;
    logic [WB_DAT_BITS-1:0]   wb_dout_q;

    // ------------------------------------------------------------------------
    //  port A, Wishbone side
    // ------------------------------------------------------------------------

    // no new request while one is in flight or being acked
    assign accept  = req_i.stb && !(|pend);
    assign wb_addr = req_i.adr[MEM_ADDR_BITS-1:0];
    assign wb_be   = {WB_SEL_BITS{accept && req_i.we}} & req_i.sel;

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            pend <= '0;
        end else begin
            pend <= {pend[MEM_LATENCY-2:0], accept};
        end
    end

    always_ff @(posedge s_wb_clk_i) begin
        if (accept) begin
            wb_rd_q <= mem[wb_addr];
        end
        // output register
        wb_dout_q <= wb_rd_q;
    end

    assign rsp_o.dat = wb_dout_q;
    assign rsp_o.ack = pend[MEM_LATENCY-1];

    // ------------------------------------------------------------------------
    //  memory array, byte writes from A, word writes from B
    // ------------------------------------------------------------------------

    always_ff @(posedge s_wb_clk_i) begin
        for (int b = 0; b < WB_SEL_BITS; b++) begin
            if (wb_be[b]) begin
                mem[wb_addr][b*(WB_DAT_BITS/WB_SEL_BITS) +: (WB_DAT_BITS/WB_SEL_BITS)]
                    <= req_i.dat[b*(WB_DAT_BITS/WB_SEL_BITS) +: (WB_DAT_BITS/WB_SEL_BITS)];
            end
        end
        if (CORE_WRITES && core_wr_i.we) begin
            mem[core_wr_i.addr] <= core_wr_i.data;
        end
    end

    // ------------------------------------------------------------------------
    //  port B, core side
    // ------------------------------------------------------------------------

    if (CORE_WRITES) begin : g_core_wr
        assign core_rdata_o = '0;
    end else begin : g_core_rd
        logic [WB_DAT_BITS-1:0] core_rd_q;

        // same two-stage latency as port A
        always_ff @(posedge s_wb_clk_i) begin
            core_rd_q    <= mem[core_raddr_i];
            core_rdata_o <= core_rd_q;
        end
    end

endmodule

`default_nettype wire

//--- source/wb_region_decode.sv
`timescale 1ns/1ps
`default_nettype none

module wb_region_decode (
    input  var vector_add_pkg::wb_req_t req_i,

    output var vector_add_pkg::wb_req_t regs_req_o,
    output var vector_add_pkg::wb_req_t mem0_req_o,
    output var vector_add_pkg::wb_req_t mem1_req_o,
    output var vector_add_pkg::wb_req_t mem2_req_o,

    input  var vector_add_pkg::wb_rsp_t regs_rsp_i,
    input  var vector_add_pkg::wb_rsp_t mem0_rsp_i,
    input  var vector_add_pkg::wb_rsp_t mem1_rsp_i,
    input  var vector_add_pkg::wb_rsp_t mem2_rsp_i,

    output var vector_add_pkg::wb_rsp_t rsp_o
);

    import vector_add_pkg::*;

    logic [REGION_BITS-1:0] region;

    // copy of the request, strobe only where the region hits
    function automatic wb_req_t route(input wb_req_t req, input logic hit);
        wb_req_t r;
        r     = req;
        r.stb = req.stb && hit;
        return r;
    endfunction

    assign region = req_i.adr[WB_ADR_BITS-1 -: REGION_BITS];

    // ------------------------------------------------------------------------
    //  request fan-out
    // ------------------------------------------------------------------------

    always_comb begin
        regs_req_o = route(req_i, region == REGION_REGS);
        mem0_req_o = route(req_i, region == REGION_MEM0);
        mem1_req_o = route(req_i, region == REGION_MEM1);
        mem2_req_o = route(req_i, region == REGION_MEM2);
    end

    // ------------------------------------------------------------------------
    //  response mux
    // ------------------------------------------------------------------------

    always_comb begin
        rsp_o = '0;
        if (req_i.stb) begin
            case (region)
                REGION_REGS: rsp_o = regs_rsp_i;
                REGION_MEM0: rsp_o = mem0_rsp_i;
                REGION_MEM1: rsp_o = mem1_rsp_i;
                REGION_MEM2: rsp_o = mem2_rsp_i;
                default:     rsp_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_vector_add_tasks.svh
`ifndef TB_VECTOR_ADD_TASKS_SVH
`define TB_VECTOR_ADD_TASKS_SVH

// ----------------------------------------------------------------------------
//  helpers
// ----------------------------------------------------------------------------

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

function automatic logic [5:0] mem_adr(input logic [1:0] region, input int idx);
    return {region, 4'(idx)};
endfunction

// each byte lane wraps on its own
function automatic logic [31:0] lane_sum(input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    for (int l = 0; l < 4; l++) begin
        res[l*8 +: 8] = a[l*8 +: 8] + b[l*8 +: 8];
    end
    return res;
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
        $display("FAIL %s got 0x%08h expected 0x%08h", name, got, want);
        stop_on_failure();
    end
endtask

// ----------------------------------------------------------------------------
//  bus access
// ----------------------------------------------------------------------------

// one Wishbone cycle with ack and data sampled on the falling edge
task automatic bus_cycle(input logic [5:0] adr, input logic [31:0] dat, input logic [3:0] sel,
                         input logic we, output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(posedge s_wb_clk_i);
    #1;
    s_wb_adr_i = adr;
    s_wb_dat_i = dat;
    s_wb_sel_i = sel;
    s_wb_we_i  = we;
    s_wb_stb_i = 1'b1;
    @(negedge s_wb_clk_i);
    while (!s_wb_ack_o && waited < TIMEOUT_CYCLES) begin
        waited++;
        @(negedge s_wb_clk_i);
    end
    if (!s_wb_ack_o) begin
        $display("timeout: no ack from the DUT for address 0x%02h", adr);
        stop_on_failure();
    end
    rdata = s_wb_dat_o;
    @(posedge s_wb_clk_i);
    #1;
    s_wb_stb_i = 1'b0;
    s_wb_we_i  = 1'b0;
endtask

task automatic wb_write(input logic [5:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] unused;
    bus_cycle(adr, dat, sel, 1'b1, unused);
endtask

task automatic wb_read(input logic [5:0] adr, output logic [31:0] rdata);
    bus_cycle(adr, 32'h0, 4'hf, 1'b0, rdata);
endtask

task automatic wait_done();
    logic [31:0] flag;
    int polls;
    polls = 0;
    wb_read(DONE_ADR, flag);
    while (flag[0] !== 1'b1 && polls < DONE_POLLS) begin
        polls++;
        wb_read(DONE_ADR, flag);
    end
    if (flag[0] !== 1'b1) begin
        $display("timeout: the done flag never came up");
        stop_on_failure();
    end
endtask

// new source vectors with some lanes at 0xff so sums wrap
task automatic fill_sources();
    for (int i = 0; i < NUM_WORDS; i++) begin
        mem0_model[i] = lcg_next();
        mem1_model[i] = lcg_next();
        if (i % 2 == 0) mem0_model[i][((i / 2) % 4)*8 +: 8] = 8'hff;
        if (i % 3 == 0) mem1_model[i][(i % 4)*8 +: 8] = 8'hff;
        wb_write(mem_adr(RGN_MEM0, i), mem0_model[i], 4'hf);
        wb_write(mem_adr(RGN_MEM1, i), mem1_model[i], 4'hf);
    end
endtask

task automatic check_result();
    logic [31:0] rdata;
    for (int i = 0; i < NUM_WORDS; i++) begin
        wb_read(mem_adr(RGN_MEM2, i), rdata);
        check($sformatf("mem2[%0d]", i), rdata, lane_sum(mem0_model[i], mem1_model[i]));
    end
endtask

// ----------------------------------------------------------------------------
//  directed tests
// ----------------------------------------------------------------------------

task automatic test_after_reset();
    logic [31:0] rdata;
    @(negedge s_wb_clk_i);
    check("s_wb_ack_o", {31'b0, s_wb_ack_o}, 32'h0);
    wb_read(START_ADR, rdata);
    check("start", rdata, 32'h0);
    wb_read(DONE_ADR, rdata);
    check("done", rdata, 32'h0);
endtask

task automatic test_mem_rw();
    logic [31:0] rdata;
    fill_sources();
    for (int i = 0; i < NUM_WORDS; i++) begin
        wb_read(mem_adr(RGN_MEM0, i), rdata);
        check($sformatf("mem0[%0d]", i), rdata, mem0_model[i]);
        wb_read(mem_adr(RGN_MEM1, i), rdata);
        check($sformatf("mem1[%0d]", i), rdata, mem1_model[i]);
    end
endtask

task automatic test_byte_select();
    logic [31:0] old_word;
    logic [31:0] new_word;
    logic [31:0] want;
    logic [31:0] rdata;
    old_word = lcg_next();
    new_word = lcg_next();
    wb_write(mem_adr(RGN_MEM2, 5), old_word, 4'hf);
    wb_write(mem_adr(RGN_MEM2, 5), new_word, 4'b0101);
    want = {old_word[31:24], new_word[23:16], old_word[15:8], new_word[7:0]};
    wb_read(mem_adr(RGN_MEM2, 5), rdata);
    check("mem2[5]", rdata, want);
endtask

task automatic test_vector_add();
    logic [31:0] rdata;
    wb_write(START_ADR, 32'h1, 4'h1);
    wait_done();
    wb_read(DONE_ADR, rdata);
    check("done", rdata, 32'h1);
    check_result();
endtask

task automatic test_rerun();
    logic [31:0] rdata;
    wb_write(DONE_ADR, 32'h0, 4'hf);
    wb_read(DONE_ADR, rdata);
    check("done", rdata, 32'h0);
    fill_sources();
    wb_write(START_ADR, 32'h1, 4'h1);
    wait_done();
    wb_read(DONE_ADR, rdata);
    check("done", rdata, 32'h1);
    check_result();
endtask

// bit 0 low so a write that leaks into the done flag would clear it
task automatic test_unused_reg();
    logic [31:0] rdata;
    wb_write(UNUSED_ADR, 32'hffff_fffe, 4'hf);
    wb_read(UNUSED_ADR, rdata);
    check("unused reg", rdata, 32'h0);
    wb_read(START_ADR, rdata);
    check("start", rdata, 32'h0);
    wb_read(DONE_ADR, rdata);
    check("done", rdata, 32'h1);
endtask

`endif

//--- testbench/tb_vector_add.sv
`timescale 1ns/1ps

module tb_vector_add;

    localparam int TIMEOUT_CYCLES = 64;
    localparam int DONE_POLLS     = 100;
    localparam int NUM_WORDS      = 16;
    localparam int LCG_SEED       = 66106;

    // region codes sit in the top two address bits
    localparam logic [1:0] RGN_MEM0   = 2'd1;
    localparam logic [1:0] RGN_MEM1   = 2'd2;
    localparam logic [1:0] RGN_MEM2   = 2'd3;
    localparam logic [5:0] START_ADR  = 6'h00;
    localparam logic [5:0] DONE_ADR   = 6'h01;
    localparam logic [5:0] UNUSED_ADR = 6'h05;

    logic        s_wb_clk_i;
    logic        s_wb_rst_i;
    logic [5:0]  s_wb_adr_i;
    logic [31:0] s_wb_dat_i;
    logic [3:0]  s_wb_sel_i;
    logic        s_wb_we_i;
    logic        s_wb_stb_i;
    logic [31:0] s_wb_dat_o;
    logic        s_wb_ack_o;

    logic [31:0] lcg_state;
    logic [31:0] mem0_model [NUM_WORDS];
    logic [31:0] mem1_model [NUM_WORDS];

    task automatic stop_on_failure();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    `include "tb_vector_add_tasks.svh"

    vector_add_top vector_add_top_i (
        .s_wb_clk_i (s_wb_clk_i),
        .s_wb_rst_i (s_wb_rst_i),
        .s_wb_adr_i (s_wb_adr_i),
        .s_wb_dat_i (s_wb_dat_i),
        .s_wb_sel_i (s_wb_sel_i),
        .s_wb_we_i  (s_wb_we_i),
        .s_wb_stb_i (s_wb_stb_i),
        .s_wb_dat_o (s_wb_dat_o),
        .s_wb_ack_o (s_wb_ack_o)
    );

    always begin
        #50 s_wb_clk_i = ~s_wb_clk_i;
    end

    initial begin
        s_wb_clk_i = 1'b0;
        s_wb_rst_i = 1'b1;
        s_wb_adr_i = '0;
        s_wb_dat_i = '0;
        s_wb_sel_i = '0;
        s_wb_we_i  = 1'b0;
        s_wb_stb_i = 1'b0;
        lcg_state  = 32'(LCG_SEED);

        repeat (10) @(posedge s_wb_clk_i);
        #1;
        s_wb_rst_i = 1'b0;

        test_after_reset();
        test_mem_rw();
        test_byte_select();
        test_vector_add();
        test_rerun();
        test_unused_reg();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
